// File: logic/net_consts.svh
// Network control path constants
// Slice depth, ARP cache geometry, statistics counter width

`ifndef NET_CONSTS_SVH
`define NET_CONSTS_SVH

// Default register slice depth between user and network side
`define NET_N_STAGES 2

// ARP cache geometry, index taken from the low IP bits
`define NET_ARP_ENTRIES 8
`define NET_ARP_IDX_BITS 3

// Width of each statistics counter
`define NET_STAT_BITS 16

`endif

// File: logic/net_ctrl_pkg.sv
// Control channel types of the network stack
// Address types, ARP opcodes, ARP request and reply messages

package net_ctrl_pkg;

  // IPv4 address
  typedef logic [31:0] ip_addr_t;

  // Ethernet MAC address
  typedef logic [47:0] mac_addr_t;

  // ARP service opcodes
  typedef enum logic {
    ARP_LOOKUP = 1'b0,
    ARP_LEARN  = 1'b1
  } arp_op_e;

  // Request towards the ARP cache
  // mac only meaningful for learn
  typedef struct packed {
    arp_op_e   op;
    ip_addr_t  ip;
    mac_addr_t mac;
  } arp_req_t;

  // Reply to a lookup
  // ip echoed from the request, mac zero on a miss
  typedef struct packed {
    logic      hit;
    ip_addr_t  ip;
    mac_addr_t mac;
  } arp_rsp_t;

endpackage

// File: logic/net_stat_pkg.sv
// Statistics types of the network stack
// Operation counters reported back to the user side

`include "net_consts.svh"

package net_stat_pkg;

  // Counters wrap at their width
  typedef logic [`NET_STAT_BITS-1:0] stat_cnt_t;

  // ARP cache operation counts
  typedef struct packed {
    stat_cnt_t lookups;
    stat_cnt_t hits;
    stat_cnt_t learns;
  } net_stat_t;

endpackage

// File: logic/reg_slice.sv
// Valid/ready register slice
// Two-entry skid buffer, full throughput, registered input ready

`timescale 1ns/1ps

module reg_slice #(
  parameter int WIDTH = 32
) (
  input  logic             aclk,
  input  logic             rst_n,
  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,
  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data
);

  // Main output register
  logic             main_valid;
  logic [WIDTH-1:0] main_data;

  // Skid register, catches the item that arrives during a stall
  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;

  // Main register free to load this cycle
  logic main_free;

  assign main_free = m_ready || !main_valid;

  // Ready only from own state, no path from m_ready
  assign s_ready = !skid_valid;

  assign m_valid = main_valid;
  assign m_data  = main_data;

  // Control state
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // Skid drains first, otherwise take the input directly
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= s_valid;
      end
    end else if (s_valid && s_ready) begin
      // Output stalled, park the incoming item
      skid_valid <= 1'b1;
    end
  end

  // Payload registers
  always_ff @(posedge aclk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (s_valid) begin
        main_data <= s_data;
      end
    end else if (s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

endmodule

// File: logic/net_slice_array.sv
// Register slice chain between user and network side
// N_STAGES slices per control channel, reply channel reversed
// Plain register pipe for the statistics record

`timescale 1ns/1ps

`include "net_consts.svh"

module net_slice_array #(
  parameter int N_STAGES = `NET_N_STAGES
) (
  input  logic                   aclk,
  input  logic                   rst_n,

  // User side
  input  logic                   s_arp_req_valid,
  output logic                   s_arp_req_ready,
  input  net_ctrl_pkg::arp_req_t s_arp_req_data,
  output logic                   m_arp_rsp_valid,
  input  logic                   m_arp_rsp_ready,
  output net_ctrl_pkg::arp_rsp_t m_arp_rsp_data,
  input  logic                   s_set_ip_valid,
  output logic                   s_set_ip_ready,
  input  net_ctrl_pkg::ip_addr_t s_set_ip_data,
  input  logic                   s_set_mac_valid,
  output logic                   s_set_mac_ready,
  input  net_ctrl_pkg::mac_addr_t s_set_mac_data,
  output net_stat_pkg::net_stat_t m_net_stats,

  // Network side
  output logic                   m_arp_req_valid,
  input  logic                   m_arp_req_ready,
  output net_ctrl_pkg::arp_req_t m_arp_req_data,
  input  logic                   s_arp_rsp_valid,
  output logic                   s_arp_rsp_ready,
  input  net_ctrl_pkg::arp_rsp_t s_arp_rsp_data,
  output logic                   m_set_ip_valid,
  input  logic                   m_set_ip_ready,
  output net_ctrl_pkg::ip_addr_t m_set_ip_data,
  output logic                   m_set_mac_valid,
  input  logic                   m_set_mac_ready,
  output net_ctrl_pkg::mac_addr_t m_set_mac_data,
  input  net_stat_pkg::net_stat_t s_net_stats
);

  // Stage boundaries, index 0 at the sending end of each channel
  logic [N_STAGES:0]       req_valid, req_ready;
  net_ctrl_pkg::arp_req_t  req_data [N_STAGES+1];
  logic [N_STAGES:0]       rsp_valid, rsp_ready;
  net_ctrl_pkg::arp_rsp_t  rsp_data [N_STAGES+1];
  logic [N_STAGES:0]       ip_valid, ip_ready;
  net_ctrl_pkg::ip_addr_t  ip_data [N_STAGES+1];
  logic [N_STAGES:0]       mac_valid, mac_ready;
  net_ctrl_pkg::mac_addr_t mac_data [N_STAGES+1];

  // Statistics pipe registers
  net_stat_pkg::net_stat_t stat_q [N_STAGES];

  // Requests and settings enter from the user
  assign req_valid[0]      = s_arp_req_valid;
  assign req_data[0]       = s_arp_req_data;
  assign s_arp_req_ready   = req_ready[0];
  assign ip_valid[0]       = s_set_ip_valid;
  assign ip_data[0]        = s_set_ip_data;
  assign s_set_ip_ready    = ip_ready[0];
  assign mac_valid[0]      = s_set_mac_valid;
  assign mac_data[0]       = s_set_mac_data;
  assign s_set_mac_ready   = mac_ready[0];

  // Replies enter from the network
  assign rsp_valid[0]      = s_arp_rsp_valid;
  assign rsp_data[0]       = s_arp_rsp_data;
  assign s_arp_rsp_ready   = rsp_ready[0];

  // Far ends
  assign m_arp_req_valid   = req_valid[N_STAGES];
  assign m_arp_req_data    = req_data[N_STAGES];
  assign req_ready[N_STAGES] = m_arp_req_ready;
  assign m_set_ip_valid    = ip_valid[N_STAGES];
  assign m_set_ip_data     = ip_data[N_STAGES];
  assign ip_ready[N_STAGES] = m_set_ip_ready;
  assign m_set_mac_valid   = mac_valid[N_STAGES];
  assign m_set_mac_data    = mac_data[N_STAGES];
  assign mac_ready[N_STAGES] = m_set_mac_ready;
  assign m_arp_rsp_valid   = rsp_valid[N_STAGES];
  assign m_arp_rsp_data    = rsp_data[N_STAGES];
  assign rsp_ready[N_STAGES] = m_arp_rsp_ready;

  assign m_net_stats = stat_q[N_STAGES-1];

  for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
    net_stat_pkg::net_stat_t stat_d;

    // ARP request, user to network
    reg_slice #(.WIDTH($bits(net_ctrl_pkg::arp_req_t))) u_req (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(req_valid[i]), .s_ready(req_ready[i]), .s_data(req_data[i]),
      .m_valid(req_valid[i+1]), .m_ready(req_ready[i+1]), .m_data(req_data[i+1])
    );

    // ARP reply, network to user
    reg_slice #(.WIDTH($bits(net_ctrl_pkg::arp_rsp_t))) u_rsp (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(rsp_valid[i]), .s_ready(rsp_ready[i]), .s_data(rsp_data[i]),
      .m_valid(rsp_valid[i+1]), .m_ready(rsp_ready[i+1]), .m_data(rsp_data[i+1])
    );

    // Own IP setting
    reg_slice #(.WIDTH($bits(net_ctrl_pkg::ip_addr_t))) u_ip (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(ip_valid[i]), .s_ready(ip_ready[i]), .s_data(ip_data[i]),
      .m_valid(ip_valid[i+1]), .m_ready(ip_ready[i+1]), .m_data(ip_data[i+1])
    );

    // Own MAC setting
    reg_slice #(.WIDTH($bits(net_ctrl_pkg::mac_addr_t))) u_mac (
      .aclk(aclk), .rst_n(rst_n),
      .s_valid(mac_valid[i]), .s_ready(mac_ready[i]), .s_data(mac_data[i]),
      .m_valid(mac_valid[i+1]), .m_ready(mac_ready[i+1]), .m_data(mac_data[i+1])
    );

    // Stats copied every cycle, no handshake
    if (i == 0) begin : g_head
      assign stat_d = s_net_stats;
    end else begin : g_link
      assign stat_d = stat_q[i-1];
    end

    always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
        stat_q[i] <= '0;
      end else begin
        stat_q[i] <= stat_d;
      end
    end
  end

endmodule

// File: logic/arp_cache.sv
// ARP cache on the network side
// Direct-mapped table indexed by low IP bits, own IP and MAC registers
// One outstanding lookup reply, operation counters

`timescale 1ns/1ps

`include "net_consts.svh"

module arp_cache (
  input  logic                    aclk,
  input  logic                    rst_n,
  input  logic                    s_arp_req_valid,
  output logic                    s_arp_req_ready,
  input  net_ctrl_pkg::arp_req_t  s_arp_req_data,
  output logic                    m_arp_rsp_valid,
  input  logic                    m_arp_rsp_ready,
  output net_ctrl_pkg::arp_rsp_t  m_arp_rsp_data,
  input  logic                    s_set_ip_valid,
  output logic                    s_set_ip_ready,
  input  net_ctrl_pkg::ip_addr_t  s_set_ip_data,
  input  logic                    s_set_mac_valid,
  output logic                    s_set_mac_ready,
  input  net_ctrl_pkg::mac_addr_t s_set_mac_data,
  output net_stat_pkg::net_stat_t m_net_stats
);

  typedef enum logic {
    ST_IDLE,
    ST_REPLY
  } state_e;

  localparam net_stat_pkg::stat_cnt_t CNT_ONE = 1;

  state_e state_q;

  // Table storage, valid bits under reset, tags and MACs plain memory
  logic [`NET_ARP_ENTRIES-1:0] tbl_valid;
  net_ctrl_pkg::ip_addr_t      tbl_ip  [`NET_ARP_ENTRIES];
  net_ctrl_pkg::mac_addr_t     tbl_mac [`NET_ARP_ENTRIES];

  // Own addresses
  net_ctrl_pkg::ip_addr_t  own_ip;
  net_ctrl_pkg::mac_addr_t own_mac;

  logic [`NET_ARP_IDX_BITS-1:0] idx;
  logic                         req_fire, lookup_fire, learn_fire;
  net_ctrl_pkg::arp_rsp_t       lkp_rsp, rsp_q;
  net_stat_pkg::net_stat_t      stats_q;

  // No new request while a reply is waiting
  assign s_arp_req_ready = (state_q == ST_IDLE);
  assign s_set_ip_ready  = 1'b1;
  assign s_set_mac_ready = 1'b1;

  assign req_fire    = s_arp_req_valid && s_arp_req_ready;
  assign lookup_fire = req_fire && (s_arp_req_data.op == net_ctrl_pkg::ARP_LOOKUP);
  assign learn_fire  = req_fire && (s_arp_req_data.op == net_ctrl_pkg::ARP_LEARN);

  assign idx = s_arp_req_data.ip[`NET_ARP_IDX_BITS-1:0];

  // Lookup result, own address takes priority over the table
  always_comb begin
    lkp_rsp.ip = s_arp_req_data.ip;
    if (s_arp_req_data.ip == own_ip) begin
      lkp_rsp.hit = 1'b1;
      lkp_rsp.mac = own_mac;
    end else if (tbl_valid[idx] && (tbl_ip[idx] == s_arp_req_data.ip)) begin
      lkp_rsp.hit = 1'b1;
      lkp_rsp.mac = tbl_mac[idx];
    end else begin
      lkp_rsp.hit = 1'b0;
      lkp_rsp.mac = '0;
    end
  end

  // Reply sequencing
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (lookup_fire) state_q <= ST_REPLY;
        ST_REPLY: if (m_arp_rsp_ready) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // Reply payload held until accepted
  always_ff @(posedge aclk) begin
    if (lookup_fire) begin
      rsp_q <= lkp_rsp;
    end
  end

  assign m_arp_rsp_valid = (state_q == ST_REPLY);
  assign m_arp_rsp_data  = rsp_q;

  // Learn overwrites the indexed entry
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      tbl_valid <= '0;
    end else if (learn_fire) begin
      tbl_valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (learn_fire) begin
      tbl_ip[idx]  <= s_arp_req_data.ip;
      tbl_mac[idx] <= s_arp_req_data.mac;
    end
  end

  // Own address registers, always ready
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      own_ip  <= '0;
      own_mac <= '0;
    end else begin
      if (s_set_ip_valid) own_ip <= s_set_ip_data;
      if (s_set_mac_valid) own_mac <= s_set_mac_data;
    end
  end

  // Counters wrap naturally
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      stats_q <= '0;
    end else begin
      if (lookup_fire) stats_q.lookups <= stats_q.lookups + CNT_ONE;
      if (lookup_fire && lkp_rsp.hit) stats_q.hits <= stats_q.hits + CNT_ONE;
      if (learn_fire) stats_q.learns <= stats_q.learns + CNT_ONE;
    end
  end

  assign m_net_stats = stats_q;

endmodule

// File: logic/net_ctrl_top.sv
// Network control path top level
// User-side channels through the slice array to the ARP cache

`timescale 1ns/1ps

`include "net_consts.svh"

module net_ctrl_top #(
  parameter int N_STAGES = `NET_N_STAGES
) (
  input  logic                    aclk,
  input  logic                    rst_n,
  input  logic                    arp_req_valid,
  output logic                    arp_req_ready,
  input  net_ctrl_pkg::arp_req_t  arp_req_data,
  output logic                    arp_rsp_valid,
  input  logic                    arp_rsp_ready,
  output net_ctrl_pkg::arp_rsp_t  arp_rsp_data,
  input  logic                    set_ip_valid,
  output logic                    set_ip_ready,
  input  net_ctrl_pkg::ip_addr_t  set_ip_data,
  input  logic                    set_mac_valid,
  output logic                    set_mac_ready,
  input  net_ctrl_pkg::mac_addr_t set_mac_data,
  output net_stat_pkg::net_stat_t net_stats
);

  // Network side of the slice array
  logic                    n_req_valid, n_req_ready;
  net_ctrl_pkg::arp_req_t  n_req_data;
  logic                    n_rsp_valid, n_rsp_ready;
  net_ctrl_pkg::arp_rsp_t  n_rsp_data;
  logic                    n_ip_valid, n_ip_ready;
  net_ctrl_pkg::ip_addr_t  n_ip_data;
  logic                    n_mac_valid, n_mac_ready;
  net_ctrl_pkg::mac_addr_t n_mac_data;
  net_stat_pkg::net_stat_t n_stats;

  net_slice_array #(.N_STAGES(N_STAGES)) u_slices (
    .aclk(aclk), .rst_n(rst_n),
    .s_arp_req_valid(arp_req_valid), .s_arp_req_ready(arp_req_ready),
    .s_arp_req_data(arp_req_data),
    .m_arp_rsp_valid(arp_rsp_valid), .m_arp_rsp_ready(arp_rsp_ready),
    .m_arp_rsp_data(arp_rsp_data),
    .s_set_ip_valid(set_ip_valid), .s_set_ip_ready(set_ip_ready), .s_set_ip_data(set_ip_data),
    .s_set_mac_valid(set_mac_valid), .s_set_mac_ready(set_mac_ready),
    .s_set_mac_data(set_mac_data),
    .m_net_stats(net_stats),
    .m_arp_req_valid(n_req_valid), .m_arp_req_ready(n_req_ready), .m_arp_req_data(n_req_data),
    .s_arp_rsp_valid(n_rsp_valid), .s_arp_rsp_ready(n_rsp_ready), .s_arp_rsp_data(n_rsp_data),
    .m_set_ip_valid(n_ip_valid), .m_set_ip_ready(n_ip_ready), .m_set_ip_data(n_ip_data),
    .m_set_mac_valid(n_mac_valid), .m_set_mac_ready(n_mac_ready), .m_set_mac_data(n_mac_data),
    .s_net_stats(n_stats)
  );

  arp_cache u_cache (
    .aclk(aclk), .rst_n(rst_n),
    .s_arp_req_valid(n_req_valid), .s_arp_req_ready(n_req_ready), .s_arp_req_data(n_req_data),
    .m_arp_rsp_valid(n_rsp_valid), .m_arp_rsp_ready(n_rsp_ready), .m_arp_rsp_data(n_rsp_data),
    .s_set_ip_valid(n_ip_valid), .s_set_ip_ready(n_ip_ready), .s_set_ip_data(n_ip_data),
    .s_set_mac_valid(n_mac_valid), .s_set_mac_ready(n_mac_ready), .s_set_mac_data(n_mac_data),
    .m_net_stats(n_stats)
  );

endmodule

// File: verification/net_ctrl_tb.sv
// Testbench for the network control path
// ARP table and own address model, reply checker, stats check

`timescale 1ns/1ps

`include "net_consts.svh"

module net_ctrl_tb;

  localparam int N_STAGES = 2;
  localparam int WAIT_LIMIT = 1000;
  localparam int SETTLE = 2 * N_STAGES + 2;
  localparam int STAT_MOD = 1 << `NET_STAT_BITS;
  localparam logic [31:0] SEED = 32'h893cabc8;
  // Own IP shares table index 5 with 10.0.0.5
  localparam net_ctrl_pkg::ip_addr_t OWN_IP = 32'hc0a8_010d;
  localparam net_ctrl_pkg::mac_addr_t OWN_MAC = 48'h0200_5e10_0001;

  logic                    aclk;
  logic                    rst_n;
  logic                    arp_req_valid, arp_req_ready;
  net_ctrl_pkg::arp_req_t  arp_req_data;
  logic                    arp_rsp_valid, arp_rsp_ready;
  net_ctrl_pkg::arp_rsp_t  arp_rsp_data;
  logic                    set_ip_valid, set_ip_ready;
  net_ctrl_pkg::ip_addr_t  set_ip_data;
  logic                    set_mac_valid, set_mac_ready;
  net_ctrl_pkg::mac_addr_t set_mac_data;
  net_stat_pkg::net_stat_t net_stats;

  // Mirror of the cache
  logic [`NET_ARP_ENTRIES-1:0] model_valid;
  net_ctrl_pkg::ip_addr_t      model_ip  [`NET_ARP_ENTRIES];
  net_ctrl_pkg::mac_addr_t     model_mac [`NET_ARP_ENTRIES];
  net_ctrl_pkg::ip_addr_t      model_own_ip;
  net_ctrl_pkg::mac_addr_t     model_own_mac;
  int                          n_lookups, n_hits, n_learns;

  // Expected replies in acceptance order
  net_ctrl_pkg::arp_rsp_t expect_q [$];

  logic [31:0] stim_rng, rdy_rng;
  logic        throttle;
  net_stat_pkg::stat_cnt_t exp_cnt;

  net_ctrl_top #(.N_STAGES(N_STAGES)) uut (
    .aclk(aclk), .rst_n(rst_n),
    .arp_req_valid(arp_req_valid), .arp_req_ready(arp_req_ready), .arp_req_data(arp_req_data),
    .arp_rsp_valid(arp_rsp_valid), .arp_rsp_ready(arp_rsp_ready), .arp_rsp_data(arp_rsp_data),
    .set_ip_valid(set_ip_valid), .set_ip_ready(set_ip_ready), .set_ip_data(set_ip_data),
    .set_mac_valid(set_mac_valid), .set_mac_ready(set_mac_ready), .set_mac_data(set_mac_data),
    .net_stats(net_stats)
  );

  always #50 aclk = ~aclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Own address takes priority over a tagged table entry
  function automatic net_ctrl_pkg::arp_rsp_t expected_reply(input net_ctrl_pkg::ip_addr_t ip);
    net_ctrl_pkg::arp_rsp_t       r;
    logic [`NET_ARP_IDX_BITS-1:0] i;
    i = ip[`NET_ARP_IDX_BITS-1:0];
    r.ip = ip;
    r.hit = 1'b0;
    r.mac = '0;
    if (ip == model_own_ip) begin
      r.hit = 1'b1;
      r.mac = model_own_mac;
    end else if (model_valid[i] && model_ip[i] == ip) begin
      r.hit = 1'b1;
      r.mac = model_mac[i];
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  // Hold one request until accepted
  // Model follows the acceptance edge
  task automatic push_req(input net_ctrl_pkg::arp_op_e op, input net_ctrl_pkg::ip_addr_t ip,
                          input net_ctrl_pkg::mac_addr_t mac);
    int                           waited;
    logic                         done;
    logic [`NET_ARP_IDX_BITS-1:0] i;
    net_ctrl_pkg::arp_rsp_t       exp;
    waited = 0;
    done = 1'b0;
    i = ip[`NET_ARP_IDX_BITS-1:0];
    arp_req_valid = 1'b1;
    arp_req_data.op = op;
    arp_req_data.ip = ip;
    arp_req_data.mac = mac;
    while (!done) begin
      @(negedge aclk);
      if (arp_req_ready) begin
        done = 1'b1;
        if (op == net_ctrl_pkg::ARP_LOOKUP) begin
          exp = expected_reply(ip);
          expect_q.push_back(exp);
          n_lookups++;
          if (exp.hit) n_hits++;
        end else begin
          model_valid[i] = 1'b1;
          model_ip[i] = ip;
          model_mac[i] = mac;
          n_learns++;
        end
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout waiting for arp_req_ready");
          abort_run();
        end
      end
      @(posedge aclk);
      #1;
    end
    arp_req_valid = 1'b0;
  endtask

  // Both own address channels raised together
  // Each valid dropped once taken, model updated at acceptance
  task automatic set_own_addr(input net_ctrl_pkg::ip_addr_t ip, input net_ctrl_pkg::mac_addr_t mac);
    int   waited;
    logic ip_done, mac_done;
    waited = 0;
    ip_done = 1'b0;
    mac_done = 1'b0;
    set_ip_valid = 1'b1;
    set_ip_data = ip;
    set_mac_valid = 1'b1;
    set_mac_data = mac;
    while (!(ip_done && mac_done)) begin
      @(negedge aclk);
      if (set_ip_valid && set_ip_ready) begin
        ip_done = 1'b1;
        model_own_ip = ip;
      end
      if (set_mac_valid && set_mac_ready) begin
        mac_done = 1'b1;
        model_own_mac = mac;
      end
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout waiting for the own address channels to accept");
        abort_run();
      end
      @(posedge aclk);
      #1;
      if (ip_done) set_ip_valid = 1'b0;
      if (mac_done) set_mac_valid = 1'b0;
    end
  endtask

  task automatic wait_replies();
    int waited;
    waited = 0;
    while (expect_q.size() != 0) begin
      @(posedge aclk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout waiting for outstanding lookup replies");
        abort_run();
      end
    end
  endtask

  task automatic check_reply(input net_ctrl_pkg::arp_rsp_t got);
    net_ctrl_pkg::arp_rsp_t exp;
    if (expect_q.size() == 0) begin
      $display("Reply arrived with no lookup outstanding");
      abort_run();
    end else begin
      exp = expect_q.pop_front();
      assert (got.hit == exp.hit) else begin
        $display("** Error: arp_rsp_data.hit got 0x%0h expected 0x%0h", got.hit, exp.hit);
        abort_run();
      end
      assert (got.ip == exp.ip) else begin
        $display("** Error: arp_rsp_data.ip got 0x%08h expected 0x%08h", got.ip, exp.ip);
        abort_run();
      end
      assert (got.mac == exp.mac) else begin
        $display("** Error: arp_rsp_data.mac got 0x%012h expected 0x%012h", got.mac, exp.mac);
        abort_run();
      end
    end
  endtask

  // Random reply ready while throttled
  always @(posedge aclk) begin
    #1;
    if (throttle) begin
      rdy_rng = xorshift32(rdy_rng);
      arp_rsp_ready = rdy_rng[0];
    end else begin
      arp_rsp_ready = 1'b1;
    end
  end

  // Reply transfer completes at the next rising edge
  always @(negedge aclk) begin
    if (rst_n && arp_rsp_valid && arp_rsp_ready) begin
      check_reply(arp_rsp_data);
    end
  end

  initial begin
    net_ctrl_pkg::arp_op_e   op;
    net_ctrl_pkg::ip_addr_t  ip;
    net_ctrl_pkg::mac_addr_t mac;
    aclk = 1'b0;
    rst_n = 1'b0;
    arp_req_valid = 1'b0;
    arp_req_data = '0;
    set_ip_valid = 1'b0;
    set_ip_data = '0;
    set_mac_valid = 1'b0;
    set_mac_data = '0;
    arp_rsp_ready = 1'b0;
    throttle = 1'b0;
    stim_rng = SEED;
    rdy_rng = ~SEED;
    model_valid = '0;
    model_own_ip = '0;
    model_own_mac = '0;
    n_lookups = 0;
    n_hits = 0;
    n_learns = 0;
    repeat (4) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    assert (arp_rsp_valid == 1'b0) else begin
      $display("** Error: arp_rsp_valid got 0x%0h expected 0x0 after reset", arp_rsp_valid);
      abort_run();
    end

    // Empty table miss
    push_req(net_ctrl_pkg::ARP_LOOKUP, 32'h0a01_0203, '0);
    wait_replies();

    // Learn then hit
    push_req(net_ctrl_pkg::ARP_LEARN, 32'h0a01_0203, 48'h0012_3456_789a);
    push_req(net_ctrl_pkg::ARP_LOOKUP, 32'h0a01_0203, '0);
    wait_replies();

    // Second learn at index 3 evicts the first
    push_req(net_ctrl_pkg::ARP_LEARN, 32'h0a02_0003, 48'h00ab_cdef_0123);
    push_req(net_ctrl_pkg::ARP_LOOKUP, 32'h0a01_0203, '0);
    push_req(net_ctrl_pkg::ARP_LOOKUP, 32'h0a02_0003, '0);
    wait_replies();

    // Own address wins over a table entry at the same index
    push_req(net_ctrl_pkg::ARP_LEARN, 32'h0a00_0005, 48'h0055_aa55_aa55);
    set_own_addr(OWN_IP, OWN_MAC);
    push_req(net_ctrl_pkg::ARP_LOOKUP, OWN_IP, '0);
    push_req(net_ctrl_pkg::ARP_LOOKUP, 32'h0a00_0005, '0);
    wait_replies();

    // Random traffic over a small aliasing IP pool
    // Own IP now and then
    throttle = 1'b1;
    for (int n = 0; n < 200; n++) begin
      stim_rng = xorshift32(stim_rng);
      op = stim_rng[31] ? net_ctrl_pkg::ARP_LEARN : net_ctrl_pkg::ARP_LOOKUP;
      ip = 32'h0a00_0000 | {27'd0, stim_rng[4:0]};
      if (stim_rng[8:5] == 4'd0) ip = OWN_IP;
      mac[47:32] = stim_rng[24:9];
      stim_rng = xorshift32(stim_rng);
      mac[31:0] = stim_rng;
      push_req(op, ip, mac);
    end
    wait_replies();
    throttle = 1'b0;

    // Stats pipe settles after the last operation
    repeat (SETTLE) @(posedge aclk);
    #1;
    exp_cnt = net_stat_pkg::stat_cnt_t'(n_lookups % STAT_MOD);
    assert (net_stats.lookups == exp_cnt) else begin
      $display("** Error: net_stats.lookups got 0x%04h expected 0x%04h", net_stats.lookups,
               exp_cnt);
      abort_run();
    end
    exp_cnt = net_stat_pkg::stat_cnt_t'(n_hits % STAT_MOD);
    assert (net_stats.hits == exp_cnt) else begin
      $display("** Error: net_stats.hits got 0x%04h expected 0x%04h", net_stats.hits, exp_cnt);
      abort_run();
    end
    exp_cnt = net_stat_pkg::stat_cnt_t'(n_learns % STAT_MOD);
    assert (net_stats.learns == exp_cnt) else begin
      $display("** Error: net_stats.learns got 0x%04h expected 0x%04h", net_stats.learns,
               exp_cnt);
      abort_run();
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
logic/net_ctrl_pkg.sv
logic/net_stat_pkg.sv
logic/reg_slice.sv
logic/net_slice_array.sv
logic/arp_cache.sv
logic/net_ctrl_top.sv
verification/net_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the net_ctrl testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module net_ctrl_tb \
  -Mdir obj_dir -o net_ctrl_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/net_ctrl_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0
